// File: tlb_defines.svh
`ifndef TLB_DEFINES_SVH
`define TLB_DEFINES_SVH

// entry count and index width
`define TLB_NUM         16
`define TLB_INDEX_W     4

// entryhi layout
`define VPN2_MSB        31
`define VPN2_LSB        13
`define ODD_BIT         12
`define ASID_MSB        7

// entrylo layout
`define PFN_MSB         25
`define PFN_LSB         6
`define C_MSB           5
`define C_LSB           3
`define D_BIT           2
`define V_BIT           1
`define G_BIT           0

// top three address bits of the unmapped kernel segments
`define SEG_KSEG0       3'b100
`define SEG_KSEG1       3'b101

`define CATTR_UNCACHED  3'd2

// index register value when tlbp finds nothing
`define PROBE_MISS      32'h8000_0000

`endif

// File: tlb_entry_pkg.sv
`default_nettype none

`include "tlb_defines.svh"

package tlb_entry_pkg;

    // entryhi fields
    typedef logic [`VPN2_MSB-`VPN2_LSB:0] vpn2_t;
    typedef logic [`ASID_MSB:0]           asid_t;

    // entrylo fields
    typedef logic [`PFN_MSB-`PFN_LSB:0]   pfn_t;
    typedef logic [`C_MSB-`C_LSB:0]       cattr_t;

    typedef logic [`TLB_INDEX_W-1:0]      tlb_index_t;

    // raw cp0 register image
    typedef logic [31:0]                  cp0_word_t;

    // one bit per entry
    typedef logic [`TLB_NUM-1:0]          match_vec_t;

endpackage

`default_nettype wire

// File: mips_addr_pkg.sv
`default_nettype none

package mips_addr_pkg;

    typedef logic [31:0] vaddr_t;

    // vaddr[31:29], kseg decode
    typedef logic [2:0]  seg_t;

    // physical address bits 31:12
    typedef logic [19:0] ptag_t;

endpackage

`default_nettype wire

// File: tlb_entry_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "tlb_defines.svh"

module tlb_entry_array (
    input  wire                       clk,
    input  wire                       resetn,

    input  wire                       i_we,
    input  tlb_entry_pkg::tlb_index_t i_w_index,
    input  tlb_entry_pkg::cp0_word_t  i_w_hi,
    input  tlb_entry_pkg::cp0_word_t  i_w_lo0,
    input  tlb_entry_pkg::cp0_word_t  i_w_lo1,

    input  tlb_entry_pkg::tlb_index_t i_r_index,
    output tlb_entry_pkg::cp0_word_t  o_r_hi,
    output tlb_entry_pkg::cp0_word_t  o_r_lo0,
    output tlb_entry_pkg::cp0_word_t  o_r_lo1,

    output tlb_entry_pkg::vpn2_t      o_vpn2 [`TLB_NUM],
    output tlb_entry_pkg::asid_t      o_asid [`TLB_NUM],
    output logic                      o_g    [`TLB_NUM],
    output tlb_entry_pkg::pfn_t       o_pfn0 [`TLB_NUM],
    output tlb_entry_pkg::pfn_t       o_pfn1 [`TLB_NUM],
    output tlb_entry_pkg::cattr_t     o_c0   [`TLB_NUM],
    output tlb_entry_pkg::cattr_t     o_c1   [`TLB_NUM],
    output logic                      o_d0   [`TLB_NUM],
    output logic                      o_d1   [`TLB_NUM],
    output logic                      o_v0   [`TLB_NUM],
    output logic                      o_v1   [`TLB_NUM]
);
    import tlb_entry_pkg::*;

    logic      w_g;
    logic      r_bypass;
    cp0_word_t w_hi_norm;
    cp0_word_t w_lo0_norm;
    cp0_word_t w_lo1_norm;
    cp0_word_t s_hi;
    cp0_word_t s_lo0;
    cp0_word_t s_lo1;

    // entry is global only if both halves say so
    assign w_g = i_w_lo0[`G_BIT] & i_w_lo1[`G_BIT];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int k = 0; k < `TLB_NUM; k++) begin
                o_vpn2[k] <= '0;
                o_asid[k] <= '0;
                o_g[k]    <= 1'b0;
                o_pfn0[k] <= '0;
                o_pfn1[k] <= '0;
                o_c0[k]   <= '0;
                o_c1[k]   <= '0;
                o_d0[k]   <= 1'b0;
                o_d1[k]   <= 1'b0;
                o_v0[k]   <= 1'b0;
                o_v1[k]   <= 1'b0;
            end
        end else if (i_we) begin
            o_vpn2[i_w_index] <= i_w_hi[`VPN2_MSB:`VPN2_LSB];
            o_asid[i_w_index] <= i_w_hi[`ASID_MSB:0];
            o_g[i_w_index]    <= w_g;
            o_pfn0[i_w_index] <= i_w_lo0[`PFN_MSB:`PFN_LSB];
            o_pfn1[i_w_index] <= i_w_lo1[`PFN_MSB:`PFN_LSB];
            o_c0[i_w_index]   <= i_w_lo0[`C_MSB:`C_LSB];
            o_c1[i_w_index]   <= i_w_lo1[`C_MSB:`C_LSB];
            o_d0[i_w_index]   <= i_w_lo0[`D_BIT];
            o_d1[i_w_index]   <= i_w_lo1[`D_BIT];
            o_v0[i_w_index]   <= i_w_lo0[`V_BIT];
            o_v1[i_w_index]   <= i_w_lo1[`V_BIT];
        end
    end

    // write words as they will read back once stored
    assign w_hi_norm  = {i_w_hi[`VPN2_MSB:`VPN2_LSB], 5'b0, i_w_hi[`ASID_MSB:0]};
    assign w_lo0_norm = {6'b0, i_w_lo0[`PFN_MSB:`V_BIT], w_g};
    assign w_lo1_norm = {6'b0, i_w_lo1[`PFN_MSB:`V_BIT], w_g};

    assign s_hi  = {o_vpn2[i_r_index], 5'b0, o_asid[i_r_index]};
    assign s_lo0 = {6'b0, o_pfn0[i_r_index], o_c0[i_r_index], o_d0[i_r_index],
                    o_v0[i_r_index], o_g[i_r_index]};
    assign s_lo1 = {6'b0, o_pfn1[i_r_index], o_c1[i_r_index], o_d1[i_r_index],
                    o_v1[i_r_index], o_g[i_r_index]};

    // same-cycle write to the read index wins
    assign r_bypass = i_we && (i_r_index == i_w_index);
    assign o_r_hi   = r_bypass ? w_hi_norm  : s_hi;
    assign o_r_lo0  = r_bypass ? w_lo0_norm : s_lo0;
    assign o_r_lo1  = r_bypass ? w_lo1_norm : s_lo1;

    a_w_index_known: assert property (
        @(posedge clk) disable iff (!resetn) i_we |-> !$isunknown(i_w_index)
    ) else $error("tlb write with unknown index");

endmodule

`default_nettype wire

// File: tlb_lookup.sv
`timescale 1ns/100ps
`default_nettype none

`include "tlb_defines.svh"

module tlb_lookup (
    input  tlb_entry_pkg::vpn2_t      i_vpn2,
    input  wire                       i_odd,
    input  tlb_entry_pkg::asid_t      i_asid,

    input  tlb_entry_pkg::vpn2_t      i_e_vpn2 [`TLB_NUM],
    input  tlb_entry_pkg::asid_t      i_e_asid [`TLB_NUM],
    input  wire                       i_e_g    [`TLB_NUM],
    input  tlb_entry_pkg::pfn_t       i_e_pfn0 [`TLB_NUM],
    input  tlb_entry_pkg::pfn_t       i_e_pfn1 [`TLB_NUM],
    input  tlb_entry_pkg::cattr_t     i_e_c0   [`TLB_NUM],
    input  tlb_entry_pkg::cattr_t     i_e_c1   [`TLB_NUM],
    input  wire                       i_e_d0   [`TLB_NUM],
    input  wire                       i_e_d1   [`TLB_NUM],
    input  wire                       i_e_v0   [`TLB_NUM],
    input  wire                       i_e_v1   [`TLB_NUM],

    output logic                      o_found,
    output tlb_entry_pkg::tlb_index_t o_index,
    output tlb_entry_pkg::pfn_t       o_pfn,
    output tlb_entry_pkg::cattr_t     o_c,
    output logic                      o_d,
    output logic                      o_v
);
    import tlb_entry_pkg::*;

    match_vec_t match;

    always_comb begin
        for (int i = 0; i < `TLB_NUM; i++) begin
            match[i] = (i_vpn2 == i_e_vpn2[i]) && ((i_asid == i_e_asid[i]) || i_e_g[i]);
        end
    end

    // scan downwards so the lowest hit is kept
    always_comb begin
        o_index = '0;
        for (int i = `TLB_NUM - 1; i >= 0; i--) begin
            if (match[i]) begin
                o_index = tlb_index_t'(i);
            end
        end
    end

    assign o_found = |match;

    // page half picked by va bit 12 and zeroed on a miss
    assign o_pfn = !o_found ? '0   : i_odd ? i_e_pfn1[o_index] : i_e_pfn0[o_index];
    assign o_c   = !o_found ? '0   : i_odd ? i_e_c1[o_index]   : i_e_c0[o_index];
    assign o_d   = !o_found ? 1'b0 : i_odd ? i_e_d1[o_index]   : i_e_d0[o_index];
    assign o_v   = !o_found ? 1'b0 : i_odd ? i_e_v1[o_index]   : i_e_v0[o_index];

endmodule

`default_nettype wire

// File: tlb_translate.sv
`timescale 1ns/100ps
`default_nettype none

`include "tlb_defines.svh"

module tlb_translate (
    input  mips_addr_pkg::vaddr_t i_vaddr,
    input  wire                   i_req,
    input  wire                   i_found,
    input  tlb_entry_pkg::pfn_t   i_pfn,
    input  tlb_entry_pkg::cattr_t i_c,
    input  wire                   i_d,
    input  wire                   i_v,

    output mips_addr_pkg::ptag_t  o_tag,
    output logic                  o_uncached,
    output logic                  o_refill,
    output logic                  o_invalid,
    output logic                  o_clean
);
    import mips_addr_pkg::*;

    seg_t seg;
    logic kseg0;
    logic kseg1;
    logic mapped;

    assign seg    = i_vaddr[31:29];
    assign kseg0  = (seg == `SEG_KSEG0);
    assign kseg1  = (seg == `SEG_KSEG1);
    assign mapped = !(kseg0 || kseg1);

    // unmapped segments just drop the top three bits
    assign o_tag = mapped ? i_pfn : {3'b0, i_vaddr[28:`ODD_BIT]};

    assign o_uncached = kseg1 || (mapped && (i_c == `CATTR_UNCACHED));

    assign o_refill  = mapped && i_req && !i_found;
    assign o_invalid = mapped && i_req && i_found && !i_v;

    // store to this page would need a modify exception
    assign o_clean = mapped && i_found && i_v && !i_d;

endmodule

`default_nettype wire

// File: tlb_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "tlb_defines.svh"

module tlb_top (
    input  wire                       clk,
    input  wire                       resetn,

    input  wire                       i_we,
    input  tlb_entry_pkg::tlb_index_t i_w_index,
    input  tlb_entry_pkg::cp0_word_t  i_w_hi,
    input  tlb_entry_pkg::cp0_word_t  i_w_lo0,
    input  tlb_entry_pkg::cp0_word_t  i_w_lo1,
    input  tlb_entry_pkg::tlb_index_t i_r_index,

    input  wire                       i_inst_en,
    input  mips_addr_pkg::vaddr_t     i_inst_vaddr,
    input  wire                       i_data_ren,
    input  wire                       i_data_wen,
    input  mips_addr_pkg::vaddr_t     i_data_vaddr,
    input  wire                       i_op_tlbp,

    output mips_addr_pkg::ptag_t      o_inst_tag,
    output logic                      o_inst_uncached,
    output mips_addr_pkg::ptag_t      o_data_tag,
    output logic                      o_data_uncached,
    output tlb_entry_pkg::cp0_word_t  o_p_index,

    output logic                      o_i_refill,
    output logic                      o_i_invalid,
    output logic                      o_d_refill,
    output logic                      o_d_invalid,
    output logic                      o_d_modify,

    output tlb_entry_pkg::cp0_word_t  o_r_hi,
    output tlb_entry_pkg::cp0_word_t  o_r_lo0,
    output tlb_entry_pkg::cp0_word_t  o_r_lo1
);
    import tlb_entry_pkg::*;

    vpn2_t      e_vpn2 [`TLB_NUM];
    asid_t      e_asid [`TLB_NUM];
    logic       e_g    [`TLB_NUM];
    pfn_t       e_pfn0 [`TLB_NUM];
    pfn_t       e_pfn1 [`TLB_NUM];
    cattr_t     e_c0   [`TLB_NUM];
    cattr_t     e_c1   [`TLB_NUM];
    logic       e_d0   [`TLB_NUM];
    logic       e_d1   [`TLB_NUM];
    logic       e_v0   [`TLB_NUM];
    logic       e_v1   [`TLB_NUM];

    asid_t      cur_asid;
    vpn2_t      d_vpn2;
    logic       d_odd;

    logic       i_found;
    pfn_t       i_pfn;
    cattr_t     i_c;
    logic       i_d;
    logic       i_v;

    logic       d_found;
    tlb_index_t d_index;
    pfn_t       d_pfn;
    cattr_t     d_c;
    logic       d_d;
    logic       d_v;
    logic       d_clean;

    tlb_entry_array u_array (
        .clk(clk), .resetn(resetn),
        .i_we(i_we), .i_w_index(i_w_index),
        .i_w_hi(i_w_hi), .i_w_lo0(i_w_lo0), .i_w_lo1(i_w_lo1),
        .i_r_index(i_r_index),
        .o_r_hi(o_r_hi), .o_r_lo0(o_r_lo0), .o_r_lo1(o_r_lo1),
        .o_vpn2(e_vpn2), .o_asid(e_asid), .o_g(e_g),
        .o_pfn0(e_pfn0), .o_pfn1(e_pfn1), .o_c0(e_c0), .o_c1(e_c1),
        .o_d0(e_d0), .o_d1(e_d1), .o_v0(e_v0), .o_v1(e_v1)
    );

    // current asid lives in the entryhi on the write bus
    assign cur_asid = i_w_hi[`ASID_MSB:0];

    // tlbp searches with entryhi instead of the data address
    assign d_vpn2 = i_op_tlbp ? i_w_hi[`VPN2_MSB:`VPN2_LSB] : i_data_vaddr[`VPN2_MSB:`VPN2_LSB];
    assign d_odd  = i_op_tlbp ? i_w_hi[`ODD_BIT] : i_data_vaddr[`ODD_BIT];

    tlb_lookup u_inst_lookup (
        .i_vpn2(i_inst_vaddr[`VPN2_MSB:`VPN2_LSB]), .i_odd(i_inst_vaddr[`ODD_BIT]),
        .i_asid(cur_asid),
        .i_e_vpn2(e_vpn2), .i_e_asid(e_asid), .i_e_g(e_g),
        .i_e_pfn0(e_pfn0), .i_e_pfn1(e_pfn1), .i_e_c0(e_c0), .i_e_c1(e_c1),
        .i_e_d0(e_d0), .i_e_d1(e_d1), .i_e_v0(e_v0), .i_e_v1(e_v1),
        .o_found(i_found), .o_index(), .o_pfn(i_pfn),
        .o_c(i_c), .o_d(i_d), .o_v(i_v)
    );

    tlb_lookup u_data_lookup (
        .i_vpn2(d_vpn2), .i_odd(d_odd), .i_asid(cur_asid),
        .i_e_vpn2(e_vpn2), .i_e_asid(e_asid), .i_e_g(e_g),
        .i_e_pfn0(e_pfn0), .i_e_pfn1(e_pfn1), .i_e_c0(e_c0), .i_e_c1(e_c1),
        .i_e_d0(e_d0), .i_e_d1(e_d1), .i_e_v0(e_v0), .i_e_v1(e_v1),
        .o_found(d_found), .o_index(d_index), .o_pfn(d_pfn),
        .o_c(d_c), .o_d(d_d), .o_v(d_v)
    );

    tlb_translate u_inst_translate (
        .i_vaddr(i_inst_vaddr), .i_req(i_inst_en),
        .i_found(i_found), .i_pfn(i_pfn), .i_c(i_c), .i_d(i_d), .i_v(i_v),
        .o_tag(o_inst_tag), .o_uncached(o_inst_uncached),
        .o_refill(o_i_refill), .o_invalid(o_i_invalid), .o_clean()
    );

    tlb_translate u_data_translate (
        .i_vaddr(i_data_vaddr), .i_req(i_data_ren | i_data_wen),
        .i_found(d_found), .i_pfn(d_pfn), .i_c(d_c), .i_d(d_d), .i_v(d_v),
        .o_tag(o_data_tag), .o_uncached(o_data_uncached),
        .o_refill(o_d_refill), .o_invalid(o_d_invalid), .o_clean(d_clean)
    );

    assign o_d_modify = d_clean & i_data_wen;

    // index register image for tlbp
    assign o_p_index = d_found ? {{(32 - `TLB_INDEX_W){1'b0}}, d_index} : `PROBE_MISS;

    // tlbp borrows the data lookup so no load or store may share its cycle
    a_tlbp_no_access: assert property (
        @(posedge clk) disable iff (!resetn) i_op_tlbp |-> !(i_data_ren || i_data_wen)
    ) else $error("tlbp together with a data access");

endmodule

`default_nettype wire

// File: tb_tlb_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "tlb_defines.svh"

module tb_tlb_top;
    import tlb_entry_pkg::*;
    import mips_addr_pkg::*;

    // drive steps in the stimulus below, used for the watchdog
    localparam int STEPS = 180;

    typedef struct packed {
        logic  tag_ok;
        ptag_t tag;
        logic  unc;
        logic  refill;
        logic  invalid;
        logic  clean;
    } port_exp_t;

    logic       clk = 1'b0;
    logic       resetn;
    logic       i_we;
    tlb_index_t i_w_index;
    cp0_word_t  i_w_hi;
    cp0_word_t  i_w_lo0;
    cp0_word_t  i_w_lo1;
    tlb_index_t i_r_index;
    logic       i_inst_en;
    vaddr_t     i_inst_vaddr;
    logic       i_data_ren;
    logic       i_data_wen;
    vaddr_t     i_data_vaddr;
    logic       i_op_tlbp;
    ptag_t      o_inst_tag;
    ptag_t      o_data_tag;
    logic       o_inst_uncached;
    logic       o_data_uncached;
    cp0_word_t  o_p_index;
    cp0_word_t  o_r_hi;
    cp0_word_t  o_r_lo0;
    cp0_word_t  o_r_lo1;
    logic       o_i_refill;
    logic       o_i_invalid;
    logic       o_d_refill;
    logic       o_d_invalid;
    logic       o_d_modify;

    // shadow entries, kept in read-back word format
    cp0_word_t  sh_hi  [`TLB_NUM];
    cp0_word_t  sh_lo0 [`TLB_NUM];
    cp0_word_t  sh_lo1 [`TLB_NUM];

    cp0_word_t  exp_r_hi;
    cp0_word_t  exp_r_lo0;
    cp0_word_t  exp_r_lo1;
    cp0_word_t  exp_p_index;
    port_exp_t  exp_i;
    port_exp_t  exp_d;
    logic [31:0] seed;
    int         errors;
    int         steps;

    tlb_top i_tlb_top (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic cp0_word_t norm_hi(input cp0_word_t w);
        return {w[31:13], 5'b0, w[7:0]};
    endfunction

    function automatic cp0_word_t norm_lo(input cp0_word_t w, input logic g);
        return {6'b0, w[25:1], g};
    endfunction

    // lowest matching entry, -1 on a miss
    function automatic int find_entry(input vpn2_t vpn2, input asid_t asid);
        int hit;
        hit = -1;
        for (int k = `TLB_NUM - 1; k >= 0; k--) begin
            if (sh_hi[k][31:13] == vpn2 && (sh_hi[k][7:0] == asid || sh_lo0[k][0])) begin
                hit = k;
            end
        end
        return hit;
    endfunction

    function automatic port_exp_t expect_port(input vaddr_t va, input logic req);
        port_exp_t e;
        cp0_word_t lo;
        int        idx;
        logic      unmapped;
        unmapped = (va[31:29] == `SEG_KSEG0) || (va[31:29] == `SEG_KSEG1);
        idx = find_entry(va[31:13], i_w_hi[7:0]);
        lo = '0;
        if (idx >= 0) begin
            lo = va[12] ? sh_lo1[idx] : sh_lo0[idx];
        end
        e.tag_ok  = unmapped || (idx >= 0);
        e.tag     = unmapped ? {3'b0, va[28:12]} : lo[25:6];
        e.unc     = (va[31:29] == `SEG_KSEG1) || (!unmapped && lo[5:3] == `CATTR_UNCACHED);
        e.refill  = !unmapped && req && (idx < 0);
        e.invalid = !unmapped && req && (idx >= 0) && !lo[1];
        e.clean   = !unmapped && (idx >= 0) && lo[1] && !lo[2];
        return e;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int k = 0; k < `TLB_NUM; k++) begin
                sh_hi[k]  <= '0;
                sh_lo0[k] <= '0;
                sh_lo1[k] <= '0;
            end
        end else if (i_we) begin
            sh_hi[i_w_index]  <= norm_hi(i_w_hi);
            sh_lo0[i_w_index] <= norm_lo(i_w_lo0, i_w_lo0[0] & i_w_lo1[0]);
            sh_lo1[i_w_index] <= norm_lo(i_w_lo1, i_w_lo0[0] & i_w_lo1[0]);
        end
    end

    always_comb begin
        logic g;
        int   hit;
        g = i_w_lo0[0] & i_w_lo1[0];
        if (i_we && i_r_index == i_w_index) begin
            exp_r_hi  = norm_hi(i_w_hi);
            exp_r_lo0 = norm_lo(i_w_lo0, g);
            exp_r_lo1 = norm_lo(i_w_lo1, g);
        end else begin
            exp_r_hi  = sh_hi[i_r_index];
            exp_r_lo0 = sh_lo0[i_r_index];
            exp_r_lo1 = sh_lo1[i_r_index];
        end
        exp_i = expect_port(i_inst_vaddr, i_inst_en);
        exp_d = expect_port(i_data_vaddr, i_data_ren | i_data_wen);
        hit = find_entry(i_w_hi[31:13], i_w_hi[7:0]);
        exp_p_index = (hit < 0) ? `PROBE_MISS : 32'(hit);
    end

    task automatic log_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        errors++;
        $display("mismatch %s got %h expected %h at %0t", name, got, want, $time);
    endtask

    ap_r_hi: assert property (@(negedge clk) disable iff (!resetn) o_r_hi == exp_r_hi)
        else log_mismatch("o_r_hi", o_r_hi, exp_r_hi);
    ap_r_lo0: assert property (@(negedge clk) disable iff (!resetn) o_r_lo0 == exp_r_lo0)
        else log_mismatch("o_r_lo0", o_r_lo0, exp_r_lo0);
    ap_r_lo1: assert property (@(negedge clk) disable iff (!resetn) o_r_lo1 == exp_r_lo1)
        else log_mismatch("o_r_lo1", o_r_lo1, exp_r_lo1);
    ap_i_tag: assert property (@(negedge clk) disable iff (!resetn)
        !exp_i.tag_ok || o_inst_tag == exp_i.tag)
        else log_mismatch("o_inst_tag", 32'(o_inst_tag), 32'(exp_i.tag));
    ap_i_unc: assert property (@(negedge clk) disable iff (!resetn)
        !exp_i.tag_ok || o_inst_uncached == exp_i.unc)
        else log_mismatch("o_inst_uncached", 32'(o_inst_uncached), 32'(exp_i.unc));
    ap_i_refill: assert property (@(negedge clk) disable iff (!resetn)
        o_i_refill == exp_i.refill)
        else log_mismatch("o_i_refill", 32'(o_i_refill), 32'(exp_i.refill));
    ap_i_invalid: assert property (@(negedge clk) disable iff (!resetn)
        o_i_invalid == exp_i.invalid)
        else log_mismatch("o_i_invalid", 32'(o_i_invalid), 32'(exp_i.invalid));
    // data lookup key is entryhi while probing
    ap_d_tag: assert property (@(negedge clk) disable iff (!resetn)
        i_op_tlbp || !exp_d.tag_ok || o_data_tag == exp_d.tag)
        else log_mismatch("o_data_tag", 32'(o_data_tag), 32'(exp_d.tag));
    ap_d_unc: assert property (@(negedge clk) disable iff (!resetn)
        i_op_tlbp || !exp_d.tag_ok || o_data_uncached == exp_d.unc)
        else log_mismatch("o_data_uncached", 32'(o_data_uncached), 32'(exp_d.unc));
    ap_d_refill: assert property (@(negedge clk) disable iff (!resetn)
        o_d_refill == exp_d.refill)
        else log_mismatch("o_d_refill", 32'(o_d_refill), 32'(exp_d.refill));
    ap_d_invalid: assert property (@(negedge clk) disable iff (!resetn)
        o_d_invalid == exp_d.invalid)
        else log_mismatch("o_d_invalid", 32'(o_d_invalid), 32'(exp_d.invalid));
    ap_d_modify: assert property (@(negedge clk) disable iff (!resetn)
        o_d_modify == (exp_d.clean && i_data_wen))
        else log_mismatch("o_d_modify", 32'(o_d_modify), 32'(exp_d.clean && i_data_wen));
    ap_p_index: assert property (@(negedge clk) disable iff (!resetn)
        !i_op_tlbp || o_p_index == exp_p_index)
        else log_mismatch("o_p_index", o_p_index, exp_p_index);

    task automatic next_cycle();
        @(posedge clk);
        #0.5;
        steps++;
    endtask

    task automatic draw(output logic [31:0] r);
        seed = lcg(seed);
        r = {seed[15:0], seed[31:16]};
    endtask

    // read index follows the write index to hit the bypass
    task automatic write_entry(input tlb_index_t idx, input cp0_word_t hi,
                               input cp0_word_t lo0, input cp0_word_t lo1);
        i_we      = 1'b1;
        i_w_index = idx;
        i_w_hi    = hi;
        i_w_lo0   = lo0;
        i_w_lo1   = lo1;
        i_r_index = idx;
        next_cycle();
        i_we      = 1'b0;
    endtask

    initial begin
        tlb_index_t  idx;
        cp0_word_t   hi;
        cp0_word_t   lo0;
        cp0_word_t   lo1;
        logic [31:0] r;
        seed         = 32'h3a31;
        errors       = 0;
        steps        = 0;
        resetn       = 1'b0;
        i_we         = 1'b0;
        i_w_index    = '0;
        i_w_hi       = '0;
        i_w_lo0      = '0;
        i_w_lo1      = '0;
        i_r_index    = '0;
        i_inst_en    = 1'b0;
        i_inst_vaddr = '0;
        i_data_ren   = 1'b0;
        i_data_wen   = 1'b0;
        i_data_vaddr = '0;
        i_op_tlbp    = 1'b0;
        repeat (16) @(posedge clk);
        #0.5;
        resetn = 1'b1;
        next_cycle();

        // distinct page pairs in kuseg, low vpn2 bits hold the index
        for (int k = 0; k < `TLB_NUM; k++) begin
            draw(hi);
            draw(lo0);
            draw(lo1);
            hi[31]    = 1'b0;
            hi[16:13] = 4'(k);
            write_entry(4'(k), hi, lo0, lo1);
        end
        for (int k = 0; k < `TLB_NUM; k++) begin
            i_r_index = 4'(k);
            next_cycle();
        end

        // mapped lookups, own asid or a random one
        for (int n = 0; n < 64; n++) begin
            draw(r);
            idx          = r[3:0];
            i_w_hi[7:0]  = r[8] ? sh_hi[idx][7:0] : r[23:16];
            i_inst_vaddr = {sh_hi[idx][31:13], r[12:0]};
            i_data_vaddr = {sh_hi[idx][31:13], r[12:0]};
            i_inst_en    = r[4];
            i_data_ren   = r[5];
            i_data_wen   = r[6];
            next_cycle();
        end

        // kseg2 and kseg3 pairs were never written
        for (int n = 0; n < 16; n++) begin
            draw(r);
            i_inst_vaddr = {2'b11, r[29:0]};
            i_data_vaddr = {2'b11, r[31:2]};
            i_inst_en    = r[0];
            i_data_ren   = r[1];
            i_data_wen   = r[2];
            next_cycle();
        end

        i_inst_en  = 1'b0;
        i_data_ren = 1'b0;
        i_data_wen = 1'b0;
        draw(lo0);
        draw(lo1);
        write_entry(4'd9, sh_hi[2], lo0, lo1);
        i_op_tlbp = 1'b1;
        i_w_hi    = sh_hi[9];
        next_cycle();
        for (int n = 0; n < 32; n++) begin
            draw(r);
            idx          = r[3:0];
            i_w_hi       = r[4] ? sh_hi[idx] : {r[31:13], 13'h0};
            i_data_vaddr = {1'b0, r[30:0]};
            if (r[5]) begin
                i_w_hi[7:0] = r[15:8];
            end
            next_cycle();
        end
        i_op_tlbp = 1'b0;

        // kseg0 and kseg1 pass through
        for (int n = 0; n < 32; n++) begin
            draw(r);
            i_inst_vaddr = {2'b10, r[0], r[31:3]};
            i_data_vaddr = {2'b10, r[1], r[28:0]};
            i_inst_en    = r[2];
            i_data_ren   = r[3];
            i_data_wen   = r[4];
            next_cycle();
        end

        i_inst_en  = 1'b0;
        i_data_ren = 1'b0;
        i_data_wen = 1'b0;
        next_cycle();
        $display("tb_tlb_top: %0d errors in %0d steps", errors, steps);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #((STEPS * 40 + 16) * 4);
        $display("timeout: the stimulus did not finish in time");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
tlb_entry_pkg.sv
mips_addr_pkg.sv
tlb_entry_array.sv
tlb_lookup.sv
tlb_translate.sv
tlb_top.sv
tb_tlb_top.sv

// File: run.sh
#!/bin/sh
# build with Verilator, run, and fail when the log reports a failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_tlb_top \
    -Mdir obj_dir -o sim_tlb -f flist.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tlb > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0
